/* aes256_cbc_dec.sv */
/*
 * AES-256 CBC decryption core, top level
 * sequencer, key store, round datapath and CBC output stage
 */
`timescale 1ns/1ps

module aes256_cbc_dec (
    input  logic                     clk,
    input  logic                     resetn,
    input  aes_dec_pkg::aes_block_t  data_i,
    input  logic                     data_valid_i,
    output aes_dec_pkg::aes_block_t  plain_o,
    output logic                     valid_o,
    output logic                     ready_o,
    output aes_dec_pkg::load_phase_t phase_o,
    output aes_dec_pkg::key_idx_t    key_idx_o
);
    import aes_dec_pkg::*;

    // sequencer strobes
    logic        key_we;
    key_idx_t    key_widx;
    logic        iv_load;
    logic        block_load;
    logic        round_start;
    round_kind_t round_kind;
    key_idx_t    key_ridx;
    logic        finish;

    // datapath
    logic        round_done;
    aes_block_t  rkey;
    aes_block_t  state;

    aes_dec_ctrl u_ctrl (
        .clk           (clk),
        .resetn        (resetn),
        .data_valid_i  (data_valid_i),
        .round_done_i  (round_done),
        .phase_o       (phase_o),
        .key_idx_o     (key_idx_o),
        .ready_o       (ready_o),
        .key_we_o      (key_we),
        .key_widx_o    (key_widx),
        .iv_load_o     (iv_load),
        .block_load_o  (block_load),
        .round_start_o (round_start),
        .round_kind_o  (round_kind),
        .key_ridx_o    (key_ridx),
        .finish_o      (finish)
    );

    aes_key_store u_keys (
        .clk     (clk),
        .resetn  (resetn),
        .we_i    (key_we),
        .widx_i  (key_widx),
        .wdata_i (data_i),
        .ridx_i  (key_ridx),
        .rkey_o  (rkey)
    );

    aes_round_unit u_round (
        .clk     (clk),
        .resetn  (resetn),
        .load_i  (block_load),
        .block_i (data_i),
        .start_i (round_start),
        .kind_i  (round_kind),
        .rkey_i  (rkey),
        .state_o (state),
        .done_o  (round_done)
    );

    aes_cbc_out u_cbc (
        .clk          (clk),
        .resetn       (resetn),
        .iv_load_i    (iv_load),
        .block_load_i (block_load),
        .data_i       (data_i),
        .finish_i     (finish),
        .state_i      (state),
        .plain_o      (plain_o),
        .valid_o      (valid_o)
    );

endmodule

/* aes_cbc_out.sv */
/*
 * CBC output stage
 * XORs the inverse-cipher result with the previous ciphertext
 */
`timescale 1ns/1ps

module aes_cbc_out (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    iv_load_i,
    input  logic                    block_load_i,
    input  aes_dec_pkg::aes_block_t data_i,
    input  logic                    finish_i,
    input  aes_dec_pkg::aes_block_t state_i,
    output aes_dec_pkg::aes_block_t plain_o,
    output logic                    valid_o
);
    import aes_dec_pkg::*;

    // chaining value for the block in progress, and that block itself
    aes_block_t prev_ct;
    aes_block_t cur_ct;

    always_ff @(posedge clk) begin
        if (iv_load_i) begin
            prev_ct <= data_i;
        end else if (finish_i) begin
            prev_ct <= cur_ct;
        end
        if (block_load_i) begin
            cur_ct <= data_i;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            plain_o <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= finish_i;
            if (finish_i) begin
                plain_o <= prev_ct ^ state_i;
            end
        end
    end

    // one block at a time, so results never come back to back
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!resetn)
        valid_o |=> !valid_o
    );

endmodule

/* aes_dec_ctrl.sv */
/*
 * load and round sequencer
 * decodes input strobes by phase, then runs fourteen inverse rounds per block
 */
`timescale 1ns/1ps
`include "aes_dec_macros.svh"

module aes_dec_ctrl (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       data_valid_i,
    input  logic                       round_done_i,
    output aes_dec_pkg::load_phase_t   phase_o,
    output aes_dec_pkg::key_idx_t      key_idx_o,
    output logic                       ready_o,
    output logic                       key_we_o,
    output aes_dec_pkg::key_idx_t      key_widx_o,
    output logic                       iv_load_o,
    output logic                       block_load_o,
    output logic                       round_start_o,
    output aes_dec_pkg::round_kind_t   round_kind_o,
    output aes_dec_pkg::key_idx_t      key_ridx_o,
    output logic                       finish_o
);
    import aes_dec_pkg::*;

    localparam key_idx_t LAST_KEY = key_idx_t'(`AES_NUM_KEYS - 1);

    typedef enum logic [2:0] {
        S_LOAD_KEYS,
        S_LOAD_IV,
        S_WAIT_BLOCK,
        S_RUN_ROUND,
        S_WAIT_DONE
    } ctrl_state_t;

    ctrl_state_t state;
    // counts up while loading keys, down while running rounds
    key_idx_t kidx;

    // ------------------------------
    // state machine
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= S_LOAD_KEYS;
            kidx  <= '0;
        end else begin
            case (state)
                S_LOAD_KEYS: begin
                    if (data_valid_i) begin
                        if (kidx == LAST_KEY) begin
                            state <= S_LOAD_IV;
                        end else begin
                            kidx <= kidx + key_idx_t'(1);
                        end
                    end
                end
                S_LOAD_IV: begin
                    if (data_valid_i) begin
                        state <= S_WAIT_BLOCK;
                    end
                end
                S_WAIT_BLOCK: begin
                    // kidx already sits at the first round key here
                    if (data_valid_i) begin
                        state <= S_RUN_ROUND;
                    end
                end
                S_RUN_ROUND: begin
                    state <= S_WAIT_DONE;
                end
                S_WAIT_DONE: begin
                    if (round_done_i) begin
                        if (kidx == '0) begin
                            kidx  <= LAST_KEY;
                            state <= S_WAIT_BLOCK;
                        end else begin
                            kidx  <= kidx - key_idx_t'(1);
                            state <= S_RUN_ROUND;
                        end
                    end
                end
                default: begin
                    state <= S_LOAD_KEYS;
                    kidx  <= '0;
                end
            endcase
        end
    end

    // ------------------------------
    // phase and strobes
    always_comb begin
        case (state)
            S_LOAD_KEYS: phase_o = PHASE_KEY;
            S_LOAD_IV:   phase_o = PHASE_IV;
            default:     phase_o = PHASE_BLOCK;
        endcase
    end

    always_comb begin
        if (kidx == LAST_KEY) begin
            round_kind_o = ROUND_FIRST;
        end else if (kidx == '0) begin
            round_kind_o = ROUND_LAST;
        end else begin
            round_kind_o = ROUND_MID;
        end
    end

    assign key_idx_o     = kidx;
    assign key_widx_o    = kidx;
    assign key_ridx_o    = kidx;
    assign ready_o       = (state == S_WAIT_BLOCK);
    assign key_we_o      = (state == S_LOAD_KEYS) && data_valid_i;
    assign iv_load_o     = (state == S_LOAD_IV) && data_valid_i;
    assign block_load_o  = ready_o && data_valid_i;
    assign round_start_o = (state == S_RUN_ROUND);
    assign finish_o      = (state == S_WAIT_DONE) && round_done_i && (kidx == '0);

    // the round unit must see the new block before its first round
    a_first_round_after_load: assert property (
        @(posedge clk) disable iff (!resetn)
        block_load_o |=> round_start_o && (round_kind_o == ROUND_FIRST)
    );

endmodule

/* aes_dec_macros.svh */
/*
 * AES-256 CBC decryption core
 * block, byte and round key sizes
 */
`ifndef AES_DEC_MACROS_SVH
`define AES_DEC_MACROS_SVH

// block and byte widths
`define AES_BLOCK_W 128
`define AES_BYTE_W 8

// bytes per block
`define AES_BYTES 16

// one slot per round key, fourteen rounds plus the initial key
`define AES_NUM_KEYS 15

`endif

/* aes_dec_pkg.sv */
/*
 * AES-256 CBC decryption core types and inverse round helpers
 * GF(2^8) arithmetic, InvShiftRows and InvMixColumns on a full block
 */
`include "aes_dec_macros.svh"

package aes_dec_pkg;

    typedef logic [`AES_BLOCK_W-1:0] aes_block_t;
    typedef logic [`AES_BYTE_W-1:0] aes_byte_t;
    typedef logic [3:0] key_idx_t;
    typedef logic [3:0] byte_idx_t;

    // which item the next input strobe carries
    typedef enum logic [1:0] {
        PHASE_KEY   = 2'd0,
        PHASE_IV    = 2'd1,
        PHASE_BLOCK = 2'd2
    } load_phase_t;

    typedef enum logic [1:0] {
        ROUND_FIRST = 2'd0,
        ROUND_MID   = 2'd1,
        ROUND_LAST  = 2'd2
    } round_kind_t;

    // ------------------------------
    // GF(2^8), polynomial 0x11b
    function automatic aes_byte_t gf_xtime(input aes_byte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t p;
        acc = '0;
        p = a;
        for (int i = 0; i < `AES_BYTE_W; i++) begin
            if (b[i]) begin
                acc = acc ^ p;
            end
            p = gf_xtime(p);
        end
        return acc;
    endfunction

    // ------------------------------
    // byte 0 of the AES state sits in the top bits of the block
    function automatic aes_block_t inv_shift_rows(input aes_block_t s);
        aes_block_t o;
        int src;
        o = '0;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                // row r rotates right by r columns
                src = r + 4 * ((c - r) & 3);
                o[`AES_BLOCK_W-1-8*(r+4*c) -: 8] = s[`AES_BLOCK_W-1-8*src -: 8];
            end
        end
        return o;
    endfunction

    function automatic aes_block_t inv_mix_columns(input aes_block_t s);
        aes_block_t o;
        aes_byte_t a0;
        aes_byte_t a1;
        aes_byte_t a2;
        aes_byte_t a3;
        int base;
        o = '0;
        for (int c = 0; c < 4; c++) begin
            base = `AES_BLOCK_W - 1 - 32 * c;
            a0 = s[base -: 8];
            a1 = s[base-8 -: 8];
            a2 = s[base-16 -: 8];
            a3 = s[base-24 -: 8];
            o[base -: 8] = gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^
                           gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09);
            o[base-8 -: 8] = gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^
                             gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d);
            o[base-16 -: 8] = gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^
                              gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b);
            o[base-24 -: 8] = gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^
                              gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e);
        end
        return o;
    endfunction

endpackage

/* aes_inv_sbox.sv */
/*
 * AES inverse S-box
 * table lookup with a registered output, one byte per cycle
 */
`timescale 1ns/1ps

module aes_inv_sbox (
    input  logic                  clk,
    input  logic                  resetn,
    input  aes_dec_pkg::aes_byte_t byte_i,
    output aes_dec_pkg::aes_byte_t byte_o
);
    // entry 0 is the leftmost byte, one table row per line
    localparam logic [0:255][7:0] INV_SBOX = {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            byte_o <= '0;
        end else begin
            byte_o <= INV_SBOX[byte_i];
        end
    end

endmodule

/* aes_key_store.sv */
/*
 * round key store
 * fifteen 128-bit slots, written at load time, read combinationally
 */
`timescale 1ns/1ps
`include "aes_dec_macros.svh"

module aes_key_store (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    we_i,
    input  aes_dec_pkg::key_idx_t   widx_i,
    input  aes_dec_pkg::aes_block_t wdata_i,
    input  aes_dec_pkg::key_idx_t   ridx_i,
    output aes_dec_pkg::aes_block_t rkey_o
);
    import aes_dec_pkg::*;

    aes_block_t mem [`AES_NUM_KEYS];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[widx_i] <= wdata_i;
        end
    end

    // selected key is ready in the cycle of the round start
    assign rkey_o = mem[ridx_i];

    // ------------------------------
    // slot 15 does not exist
    a_widx_range: assert property (
        @(posedge clk) disable iff (!resetn)
        we_i |-> (widx_i < `AES_NUM_KEYS)
    );

endmodule

/* aes_round_unit.sv */
/*
 * inverse round datapath
 * AddRoundKey, InvMixColumns, InvShiftRows, then a byte-serial InvSubBytes pass
 */
`timescale 1ns/1ps
`include "aes_dec_macros.svh"

module aes_round_unit (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     load_i,
    input  aes_dec_pkg::aes_block_t  block_i,
    input  logic                     start_i,
    input  aes_dec_pkg::round_kind_t kind_i,
    input  aes_dec_pkg::aes_block_t  rkey_i,
    output aes_dec_pkg::aes_block_t  state_o,
    output logic                     done_o
);
    import aes_dec_pkg::*;

    localparam byte_idx_t LAST_BYTE = byte_idx_t'(`AES_BYTES - 1);

    aes_block_t state_q;
    aes_block_t ark;
    aes_block_t xform;

    // issue side feeds the S-box, write side catches its output a cycle later
    logic      issue_act;
    byte_idx_t issue_idx;
    logic      wr_act;
    byte_idx_t wr_idx;
    logic      done_q;

    aes_byte_t sbox_in;
    aes_byte_t sbox_out;

    // ------------------------------
    // whole-block part of the round
    always_comb begin
        ark = state_q ^ rkey_i;
        case (kind_i)
            ROUND_FIRST: xform = inv_shift_rows(ark);
            ROUND_MID:   xform = inv_shift_rows(inv_mix_columns(ark));
            default:     xform = ark;
        endcase
    end

    assign sbox_in = state_q[`AES_BYTE_W * issue_idx +: `AES_BYTE_W];

    aes_inv_sbox u_sbox (
        .clk    (clk),
        .resetn (resetn),
        .byte_i (sbox_in),
        .byte_o (sbox_out)
    );

    // ------------------------------
    // state register
    always_ff @(posedge clk) begin
        if (load_i) begin
            state_q <= block_i;
        end else if (start_i) begin
            state_q <= xform;
        end else if (wr_act) begin
            // substituted byte goes back to where it came from
            state_q[`AES_BYTE_W * wr_idx +: `AES_BYTE_W] <= sbox_out;
        end
    end

    // ------------------------------
    // byte pass control
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            issue_act <= 1'b0;
            issue_idx <= '0;
            wr_act    <= 1'b0;
            wr_idx    <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            wr_act <= issue_act;
            wr_idx <= issue_idx;
            if (start_i) begin
                issue_idx <= '0;
                if (kind_i == ROUND_LAST) begin
                    // final round has no substitution
                    done_q <= 1'b1;
                end else begin
                    issue_act <= 1'b1;
                end
            end else if (issue_act) begin
                issue_idx <= issue_idx + byte_idx_t'(1);
                if (issue_idx == LAST_BYTE) begin
                    issue_act <= 1'b0;
                end
            end
            if (wr_act && (wr_idx == LAST_BYTE)) begin
                done_q <= 1'b1;
            end
        end
    end

    assign state_o = state_q;
    assign done_o  = done_q;

    // a new round would overwrite bytes still on their way through the S-box
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!resetn)
        start_i |-> !(issue_act || wr_act)
    );

endmodule

/* compile.f */
+incdir+.
aes_dec_pkg.sv
aes_inv_sbox.sv
aes_key_store.sv
aes_dec_ctrl.sv
aes_round_unit.sv
aes_cbc_out.sv
aes256_cbc_dec.sv
tb_aes256_cbc_dec.sv

/* tb_aes_ref.svh */
/*
 * testbench reference model for AES-256 CBC decryption
 * S-box from the field inverse and affine map, inverse rounds, CBC step
 */
`ifndef TB_AES_REF_SVH
`define TB_AES_REF_SVH

// round keys as loaded into the DUT, slot 0 first
aes_block_t round_keys [`AES_NUM_KEYS];
logic [7:0] inv_sub_table [256];

// InvShiftRows source position of each output byte, byte 0 first
localparam logic [0:15][3:0] UNSHIFT_SRC = {
    4'd0, 4'd13, 4'd10, 4'd7, 4'd4, 4'd1, 4'd14, 4'd11,
    4'd8, 4'd5, 4'd2, 4'd15, 4'd12, 4'd9, 4'd6, 4'd3
};

// ------------------------------
// field arithmetic, Horner form from the top bit of b
function automatic logic [7:0] field_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] r;
    r = 8'h00;
    for (int i = 7; i >= 0; i--) begin
        r = {r[6:0], 1'b0} ^ (r[7] ? 8'h1b : 8'h00);
        if (b[i]) begin
            r = r ^ a;
        end
    end
    return r;
endfunction

// brute force search, zero maps to zero
function automatic logic [7:0] field_inverse(input logic [7:0] a);
    logic [7:0] inv;
    inv = 8'h00;
    for (int b = 1; b < 256; b++) begin
        if (field_mul(a, 8'(b)) == 8'h01) begin
            inv = 8'(b);
        end
    end
    return inv;
endfunction

function automatic logic [7:0] rotl8(input logic [7:0] x, input int n);
    return (x << n) | (x >> (8 - n));
endfunction

function automatic logic [7:0] forward_sbox(input logic [7:0] a);
    logic [7:0] b;
    b = field_inverse(a);
    return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
endfunction

function automatic void build_inv_sub_table();
    for (int a = 0; a < 256; a++) begin
        inv_sub_table[forward_sbox(8'(a))] = 8'(a);
    end
endfunction

// ------------------------------
// block helpers, byte 0 is the leftmost byte
function automatic logic [7:0] byte_at(input aes_block_t b, input int k);
    return b[127 - 8 * k -: 8];
endfunction

function automatic aes_block_t unshift_rows(input aes_block_t b);
    aes_block_t o;
    o = '0;
    for (int k = 0; k < 16; k++) begin
        o[127 - 8 * k -: 8] = byte_at(b, int'(UNSHIFT_SRC[k]));
    end
    return o;
endfunction

function automatic aes_block_t unmix_columns(input aes_block_t b);
    aes_block_t o;
    logic [7:0] acc;
    logic [0:3][7:0] coef;
    coef = {8'h0e, 8'h0b, 8'h0d, 8'h09};
    o = '0;
    for (int c = 0; c < 4; c++) begin
        for (int i = 0; i < 4; i++) begin
            acc = 8'h00;
            for (int j = 0; j < 4; j++) begin
                acc = acc ^ field_mul(coef[(j - i + 4) % 4], byte_at(b, 4 * c + j));
            end
            o[127 - 8 * (4 * c + i) -: 8] = acc;
        end
    end
    return o;
endfunction

function automatic aes_block_t inv_sub_bytes(input aes_block_t b);
    aes_block_t o;
    o = '0;
    for (int k = 0; k < 16; k++) begin
        o[127 - 8 * k -: 8] = inv_sub_table[byte_at(b, k)];
    end
    return o;
endfunction

// ------------------------------
// standard inverse cipher with the loaded round keys
function automatic aes_block_t decrypt_block(input aes_block_t ct);
    aes_block_t s;
    s = ct ^ round_keys[14];
    for (int r = 13; r >= 1; r--) begin
        s = inv_sub_bytes(unshift_rows(s));
        s = unmix_columns(s ^ round_keys[r]);
    end
    s = inv_sub_bytes(unshift_rows(s));
    return s ^ round_keys[0];
endfunction

function automatic aes_block_t cbc_expected(input aes_block_t ct, input aes_block_t chain);
    return decrypt_block(ct) ^ chain;
endfunction

`endif

/* tb_aes256_cbc_dec.sv */
/*
 * testbench for the AES-256 CBC decryption core
 * random keys and ciphertexts checked against a reference model
 */
`timescale 1ns/1ps
`include "aes_dec_macros.svh"

module tb_aes256_cbc_dec;
    import aes_dec_pkg::*;

    localparam int TIMEOUT_CYCLES = 1000;

    logic        clk;
    logic        resetn;
    aes_block_t  data_i;
    logic        data_valid_i;
    aes_block_t  plain_o;
    logic        valid_o;
    logic        ready_o;
    load_phase_t phase_o;
    key_idx_t    key_idx_o;

    `include "tb_aes_ref.svh"

    // previous ciphertext, or the IV before the first block
    aes_block_t chain_ct;
    aes_block_t expected_q [$];
    int         blocks_sent = 0;
    int         results_checked = 0;
    logic [15:0] lfsr_state = 16'd61050;

    aes256_cbc_dec UUT (
        .clk          (clk),
        .resetn       (resetn),
        .data_i       (data_i),
        .data_valid_i (data_valid_i),
        .plain_o      (plain_o),
        .valid_o      (valid_o),
        .ready_o      (ready_o),
        .phase_o      (phase_o),
        .key_idx_o    (key_idx_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic aes_block_t random_block();
        aes_block_t b;
        b = '0;
        for (int i = 0; i < 128; i++) begin
            b = {b[126:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return b;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s, got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    // ------------------------------
    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        while (!ready_o) begin
            if (cycles == TIMEOUT_CYCLES) begin
                abort_run("TIMEOUT: ready_o never went high");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_for_results();
        int cycles;
        cycles = 0;
        while (results_checked != blocks_sent) begin
            if (cycles == TIMEOUT_CYCLES) begin
                abort_run("TIMEOUT: valid_o never pulsed for a sent block");
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
        check_equal(ready_o, 1'b1, "ready_o after result");
    endtask

    task automatic check_reset_state();
        check_equal(valid_o, 1'b0, "valid_o after reset");
        check_equal(ready_o, 1'b0, "ready_o after reset");
        check_equal(phase_o, PHASE_KEY, "phase_o after reset");
        check_equal(key_idx_o, 4'd0, "key_idx_o after reset");
    endtask

    // fifteen key strobes back to back, then the IV
    task automatic load_keys_and_iv();
        for (int k = 0; k < `AES_NUM_KEYS; k++) begin
            check_equal(phase_o, PHASE_KEY, "phase_o during key load");
            check_equal(key_idx_o, k, "key_idx_o during key load");
            round_keys[k] = random_block();
            data_i = round_keys[k];
            data_valid_i = 1'b1;
            @(negedge clk);
            data_valid_i = 1'b0;
        end
        check_equal(phase_o, PHASE_IV, "phase_o after keys");
        chain_ct = random_block();
        data_i = chain_ct;
        data_valid_i = 1'b1;
        @(negedge clk);
        data_valid_i = 1'b0;
        check_equal(phase_o, PHASE_BLOCK, "phase_o after IV");
        check_equal(ready_o, 1'b1, "ready_o after IV");
    endtask

    task automatic send_block(input aes_block_t ct);
        wait_for_ready();
        expected_q.push_back(cbc_expected(ct, chain_ct));
        chain_ct = ct;
        data_i = ct;
        data_valid_i = 1'b1;
        @(negedge clk);
        data_valid_i = 1'b0;
        blocks_sent++;
    endtask

    // ------------------------------
    // compare every result against the oldest expected plaintext
    always @(negedge clk) begin
        if (resetn && valid_o) begin
            if (expected_q.size() == 0) begin
                abort_run("valid_o pulsed with no block in flight");
            end else begin
                check_equal(plain_o, expected_q.pop_front(), "plaintext");
                results_checked++;
            end
        end
    end

    initial begin
        resetn = 1'b0;
        data_i = '0;
        data_valid_i = 1'b0;
        build_inv_sub_table();
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_reset_state();
        load_keys_and_iv();

        // one block chained on the IV, then four more
        send_block(random_block());
        wait_for_results();
        repeat (4) begin
            send_block(random_block());
            wait_for_results();
        end

        // strobes while busy must be dropped
        send_block(random_block());
        for (int i = 0; i < 6; i++) begin
            check_equal(ready_o, 1'b0, "ready_o while busy");
            data_i = random_block();
            data_valid_i = 1'b1;
            @(negedge clk);
        end
        data_valid_i = 1'b0;
        wait_for_results();

        // reset in the middle of a block
        send_block(random_block());
        repeat (10) @(negedge clk);
        resetn = 1'b0;
        expected_q.delete();
        blocks_sent = 0;
        results_checked = 0;
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_reset_state();
        load_keys_and_iv();
        repeat (2) begin
            send_block(random_block());
            wait_for_results();
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule
